/* filelist.f */
+incdir+.
px_pkg.sv
bus_pkg.sv
px_state.sv
bus_arbiter.sv
bus_drive.sv
px_top.sv
tb_px.sv

/* Bender.yml */
package:
  name: px_ctrl

sources:
  - px_pkg.sv
  - bus_pkg.sv
  - px_state.sv
  - bus_arbiter.sv
  - bus_drive.sv
  - px_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_px.sv

/* tb_px_checks.svh */
// P-X testbench compare tasks: typed value checks with per-kind error counters
`ifndef TB_PX_CHECKS_SVH
`define TB_PX_CHECKS_SVH

int err_state = 0; // Wrong control states
int err_word  = 0; // Wrong data words
int err_sel   = 0; // Wrong address selects
int err_bit   = 0; // Wrong single-bit levels

task automatic check_state(input string name, input px_state_t act, input px_state_t exp);
	if (act !== exp) begin
		err_state++;
		$display("Fail at %0t: %s got %s (%0d) expected %s (%0d)",
			$time, name, act.name(), act, exp.name(), exp);
	end
endtask

task automatic check_word(input string name, input word_t act, input word_t exp);
	if (act !== exp) begin
		err_word++;
		$display("Fail at %0t: %s got %h expected %h", $time, name, act, exp);
	end
endtask

task automatic check_sel(input string name, input ad_sel_t act, input ad_sel_t exp);
	if (act !== exp) begin
		err_sel++;
		$display("Fail at %0t: %s got %0d expected %0d", $time, name, act, exp);
	end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
	if (act !== exp) begin
		err_bit++;
		$display("Fail at %0t: %s got %b expected %b", $time, name, act, exp);
	end
endtask

// Sum over all kinds
function automatic int total_errors();
	return err_state + err_word + err_sel + err_bit;
endfunction

task automatic report_counts();
	$display("Errors: state %0d, word %0d, select %0d, bit %0d, total %0d",
		err_state, err_word, err_sel, err_bit, total_errors());
endtask

`endif

/* tb_px.sv */
// P-X testbench driving directed tests of the state control unit through a bus responder
`timescale 1ns/1ps
`default_nettype none

module tb_px
	import px_pkg::*;
	import bus_pkg::*;
();

	localparam int ALARM_TICKS = 8; // Reply timeout in the DUT
	localparam int PERIOD_NS   = 4;
	localparam int BUS_CYC     = ALARM_TICKS + 6; // Worst bus cycle incl. request and close
	localparam int T_RESET     = 20;
	localparam int T_STEP      = BUS_CYC + 6;
	localparam int T_OPRD      = 2 * BUS_CYC + 6;
	localparam int T_OPWR      = 3 * BUS_CYC + 8;
	localparam int T_IRQ       = 3 * BUS_CYC + 8;
	localparam int T_ALARM     = 2 * BUS_CYC + 16; // Fetch, alarm cycle and final reset
	localparam int MARGIN      = 100;
	localparam int TIMEOUT_NS  =
		(T_RESET + T_STEP + T_OPRD + T_OPWR + T_IRQ + T_ALARM + MARGIN) * PERIOD_NS;

	logic      got;
	logic      clo_;
	logic      start;
	logic      mode;
	logic      przerw;
	logic      zw;
	logic      ok_;
	word_t     rdata;
	word_t     ic;
	word_t     ac;
	px_state_t state;
	logic      zg;
	logic      dr_;
	logic      dw_;
	logic      awaria;
	ad_sel_t   ad_sel;
	word_t     wdata;
	word_t     ir;
	word_t     arg;
	integer    seed = 32'h5d27; // Responder delay seed

	`include "tb_px_checks.svh"

	px_top #(
		.ALARM_TICKS (ALARM_TICKS)
	) dut (
		.got    (got),
		.clo_   (clo_),
		.start  (start),
		.mode   (mode),
		.przerw (przerw),
		.zw     (zw),
		.ok_    (ok_),
		.rdata  (rdata),
		.ic     (ic),
		.ac     (ac),
		.state  (state),
		.zg     (zg),
		.dr_    (dr_),
		.dw_    (dw_),
		.awaria (awaria),
		.ad_sel (ad_sel),
		.wdata  (wdata),
		.ir     (ir),
		.arg    (arg)
	);

	always #(PERIOD_NS / 2) got = ~got;

	// Bus responder granting the request and replying after a random wait
	task automatic serve_cycle(input word_t data, input logic give_reply,
		output logic rd_s, output logic wr_s, output ad_sel_t sel_s, output word_t wd_s);
		int delay;
		rdata = ~data; // Junk until reply
		while (!zg) @(negedge got);
		zw = 1'b1;
		#1; // Let strobes settle on the grant
		rd_s  = dr_;
		wr_s  = dw_;
		sel_s = ad_sel;
		wd_s  = wdata;
		delay = 1 + ($unsigned($random(seed)) % (ALARM_TICKS - 1)); // Stays under alarm
		repeat (delay) @(negedge got);
		if (give_reply) begin
			ok_   = 1'b0;
			rdata = data;
			@(negedge got);
			ok_   = 1'b1;
		end
		while (zg) @(negedge got); // Request drops as the cycle closes
		zw = 1'b0;
	endtask

	// Fetch one word from P0 and leave the state in K2
	task automatic fetch(input word_t word);
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		start = 1'b1;
		@(negedge got);
		start = 1'b0;
		check_state("state", state, K1);
		serve_cycle(word, 1'b1, rd_s, wr_s, sel_s, wd_s);
		check_bit("dr_", rd_s, 1'b0);
		check_sel("ad_sel", sel_s, AD_IC);
		check_state("state", state, K2);
		check_word("ir", ir, word);
	endtask

	task automatic reset_state();
		check_state("state", state, P0);
		check_bit("zg", zg, 1'b0);
		check_bit("dr_", dr_, 1'b1);
		check_bit("dw_", dw_, 1'b1);
		check_sel("ad_sel", ad_sel, AD_NONE);
		check_word("ir", ir, 16'h0000);
		check_word("arg", arg, 16'h0000);
		check_bit("awaria", awaria, 1'b0);
	endtask

	task automatic step_fetch();
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		mode  = 1'b1; // Stop after each instruction
		start = 1'b1;
		@(negedge got);
		start = 1'b0;
		check_state("state", state, K1);
		check_bit("zg", zg, 1'b0); // Request is one edge behind
		@(negedge got);
		check_bit("zg", zg, 1'b1);
		serve_cycle(16'h0123, 1'b1, rd_s, wr_s, sel_s, wd_s);
		check_bit("dr_", rd_s, 1'b0);
		check_bit("dw_", wr_s, 1'b1);
		check_sel("ad_sel", sel_s, AD_IC);
		check_word("ir", ir, 16'h0123);
		check_state("state", state, K2);
		@(negedge got);
		check_state("state", state, P0); // No operand bits in step mode
	endtask

	task automatic operand_read();
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		fetch(16'h8005); // Bit 15 asks for a read
		@(negedge got);
		check_state("state", state, WR);
		serve_cycle(16'hbeef, 1'b1, rd_s, wr_s, sel_s, wd_s);
		check_bit("dr_", rd_s, 1'b0);
		check_bit("dw_", wr_s, 1'b1);
		check_sel("ad_sel", sel_s, AD_AR);
		check_word("arg", arg, 16'hbeef);
		check_state("state", state, P0);
	endtask

	task automatic operand_write();
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		mode = 1'b0; // Run on to the next fetch
		fetch(16'h4007); // Only bit 14 asks for a write
		@(negedge got);
		check_state("state", state, WW);
		serve_cycle(16'h0000, 1'b1, rd_s, wr_s, sel_s, wd_s);
		check_bit("dw_", wr_s, 1'b0);
		check_bit("dr_", rd_s, 1'b1);
		check_word("wdata", wd_s, ac);
		check_sel("ad_sel", sel_s, AD_AR);
		check_state("state", state, K1);
		mode = 1'b1;
		serve_cycle(16'h0000, 1'b1, rd_s, wr_s, sel_s, wd_s); // Empty word stops the run
		check_word("ir", ir, 16'h0000);
		check_state("state", state, K2);
		@(negedge got);
		check_state("state", state, P0);
	endtask

	task automatic interrupt_entry();
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		przerw = 1'b1; // Pending before the instruction ends
		fetch(16'h0001);
		@(negedge got);
		check_state("state", state, I1);
		przerw = 1'b0;
		@(negedge got);
		check_state("state", state, I2);
		serve_cycle(16'h0000, 1'b1, rd_s, wr_s, sel_s, wd_s); // Return address store
		check_bit("dw_", wr_s, 1'b0);
		check_word("wdata", wd_s, ic);
		check_sel("ad_sel", sel_s, AD_IC);
		check_state("state", state, I3);
		serve_cycle(16'h00a0, 1'b1, rd_s, wr_s, sel_s, wd_s); // Vector read
		check_bit("dr_", rd_s, 1'b0);
		check_sel("ad_sel", sel_s, AD_VEC);
		check_word("arg", arg, 16'h00a0);
		check_state("state", state, P0);
	endtask

	task automatic no_reply_alarm();
		logic    rd_s;
		logic    wr_s;
		ad_sel_t sel_s;
		word_t   wd_s;
		fetch(16'h8000);
		@(negedge got);
		check_state("state", state, WR);
		check_bit("awaria", awaria, 1'b0);
		serve_cycle(16'h1111, 1'b0, rd_s, wr_s, sel_s, wd_s); // Grant without any ok_
		check_bit("awaria", awaria, 1'b1);
		check_word("arg", arg, 16'h00a0); // Old vector word kept
		check_state("state", state, P0);
		repeat (4) begin
			@(negedge got);
			check_bit("awaria", awaria, 1'b1); // Sticky
		end
		clo_ = 1'b0;
		repeat (2) @(negedge got);
		clo_ = 1'b1;
		check_bit("awaria", awaria, 1'b0);
	endtask

	initial begin
		got    = 1'b0;
		clo_   = 1'b0;
		start  = 1'b0;
		mode   = 1'b1;
		przerw = 1'b0;
		zw     = 1'b0;
		ok_    = 1'b1;
		rdata  = '0;
		ic     = 16'h0456;
		ac     = 16'h1234;
		repeat (16) @(negedge got);
		clo_ = 1'b1;
		reset_state();
		step_fetch();
		operand_read();
		operand_write();
		interrupt_entry();
		no_reply_alarm();
		report_counts();
		if (total_errors() == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog over the summed test lengths
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		report_counts();
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* px_top.sv */
// P-X top: sequencer, bus arbiter and bus driver of the state control unit
`timescale 1ns/1ps
`default_nettype none

module px_top
	import px_pkg::*;
	import bus_pkg::*;
#(
	parameter int ALARM_TICKS = 8 // Reply timeout in got cycles
) (
	input  logic      got,    // System clock
	input  logic      clo_,   // General clear
	input  logic      start,  // Start request
	input  logic      mode,   // Step mode
	input  logic      przerw, // Interrupt pending
	input  logic      zw,     // Bus grant
	input  logic      ok_,    // Reply, active low
	input  word_t     rdata,  // Read data
	input  word_t     ic,     // Instruction counter
	input  word_t     ac,     // Accumulator
	output px_state_t state,  // Control state
	output logic      zg,     // Bus request
	output logic      dr_,    // Read strobe
	output logic      dw_,    // Write strobe
	output logic      awaria, // No-reply alarm
	output ad_sel_t   ad_sel, // Address source
	output word_t     wdata,  // Write data
	output word_t     ir,     // Instruction register
	output word_t     arg     // Argument register
);

	bus_cycle_t cyc;      // Bus need of state
	logic       zwzg;     // Granted request
	logic       bus_done; // Cycle complete

	px_state u_state (
		.got      (got),
		.clo_     (clo_),
		.start    (start),
		.mode     (mode),
		.przerw   (przerw),
		.bus_done (bus_done),
		.ir       (ir),
		.state    (state),
		.cyc      (cyc)
	);

	bus_arbiter #(
		.ALARM_TICKS (ALARM_TICKS)
	) u_arbiter (
		.got      (got),
		.clo_     (clo_),
		.state    (state),
		.cyc      (cyc),
		.zw       (zw),
		.ok_      (ok_),
		.zg       (zg),
		.zwzg     (zwzg),
		.bus_done (bus_done),
		.awaria   (awaria)
	);

	bus_drive u_drive (
		.got    (got),
		.clo_   (clo_),
		.state  (state),
		.cyc    (cyc),
		.zwzg   (zwzg),
		.ok_    (ok_),
		.rdata  (rdata),
		.ic     (ic),
		.ac     (ac),
		.dr_    (dr_),
		.dw_    (dw_),
		.ad_sel (ad_sel),
		.wdata  (wdata),
		.ir     (ir),
		.arg    (arg)
	);

endmodule

`default_nettype wire

/* bus_drive.sv */
// Bus driver: decodes the state into bus strobes and address select and latches read data
`timescale 1ns/1ps
`default_nettype none

module bus_drive
	import px_pkg::*;
	import bus_pkg::*;
(
	input  logic       got,    // System clock
	input  logic       clo_,   // General clear
	input  px_state_t  state,  // Current control state
	input  bus_cycle_t cyc,    // Bus need of current state
	input  logic       zwzg,   // Requested and granted
	input  logic       ok_,    // Reply, active low
	input  word_t      rdata,  // Read data from bus
	input  word_t      ic,     // Instruction counter
	input  word_t      ac,     // Accumulator
	output logic       dr_,    // Read strobe, active low
	output logic       dw_,    // Write strobe, active low
	output ad_sel_t    ad_sel, // Address source
	output word_t      wdata,  // Write data to bus
	output word_t      ir,     // Instruction register
	output word_t      arg     // Argument register
);

	logic rok; // Granted reply

	assign rok = zwzg & ~ok_;

	// Strobes only while the bus is ours
	assign dr_ = ~(zwzg && cyc == BC_READ);
	assign dw_ = ~(zwzg && cyc == BC_WRITE);

	always_comb begin
		ad_sel = AD_NONE;
		if (zwzg) begin
			case (state)
				K1, I2:  ad_sel = AD_IC;  // Fetch and return address
				WR, WW:  ad_sel = AD_AR;  // Operand access
				I3:      ad_sel = AD_VEC; // Vector slot
				default: ad_sel = AD_NONE;
			endcase
		end
	end

	always_comb begin
		case (state)
			WW:      wdata = ac; // Operand store
			I2:      wdata = ic; // Return address
			default: wdata = '0;
		endcase
	end

	// Reply data latches
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ir  <= '0;
			arg <= '0;
		end else if (rok) begin
			if (state == K1) begin
				ir <= rdata; // Fetched instruction
			end
			if (state == WR || state == I3) begin
				arg <= rdata; // Operand or vector word
			end
		end
	end

endmodule

`default_nettype wire

/* bus_arbiter.sv */
// Bus arbiter: holds the bus request, watches for the reply and raises the no-reply alarm
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import px_pkg::*;
#(
	parameter int ALARM_TICKS = 8 // Granted cycles without reply before alarm
) (
	input  logic       got,      // System clock
	input  logic       clo_,     // General clear
	input  px_state_t  state,    // Current control state
	input  bus_cycle_t cyc,      // Bus need of current state
	input  logic       zw,       // Bus grant
	input  logic       ok_,      // Reply, active low
	output logic       zg,       // Bus request
	output logic       zwzg,     // Requested and granted
	output logic       bus_done, // One-cycle completion pulse
	output logic       awaria    // Sticky no-reply alarm
);

	localparam int CNT_W = $clog2(ALARM_TICKS + 1); // Alarm counter width

	px_state_t        state_q; // State seen on previous cycle
	logic [CNT_W-1:0] cnt;     // Granted cycles without reply
	logic             fresh;   // State just entered
	logic             reply;   // Valid reply this cycle
	logic             timeout; // Alarm limit reached this cycle

	assign zwzg    = zg & zw;
	assign fresh   = (state != state_q);
	assign reply   = zwzg & ~ok_ & ~bus_done; // Ignore ok_ once cycle is closing
	assign timeout = zwzg & ~ok_ ? 1'b0 : zwzg & ~bus_done & (cnt == CNT_W'(ALARM_TICKS - 1));

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state_q <= P0;
		end else begin
			state_q <= state;
		end
	end

	// Request flip-flop
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			zg <= 1'b0;
		end else if (bus_done) begin
			zg <= 1'b0; // Drops together with bus_done
		end else if (fresh && cyc != BC_NONE) begin
			zg <= 1'b1; // New bus state
		end
	end

	// Alarm counter, idle until granted
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cnt <= '0;
		end else if (!zwzg || bus_done || reply) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Completion pulse and alarm flag
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			bus_done <= 1'b0;
			awaria   <= 1'b0;
		end else begin
			bus_done <= reply | timeout; // Either ends the cycle
			if (timeout) begin
				awaria <= 1'b1; // Held until clear
			end
		end
	end

endmodule

`default_nettype wire

/* px_state.sv */
// P-X state sequencer: steps the machine through fetch, decode, operand and interrupt states
`timescale 1ns/1ps
`default_nettype none

module px_state
	import px_pkg::*;
	import bus_pkg::*;
(
	input  logic       got,      // System clock
	input  logic       clo_,     // General clear
	input  logic       start,    // Start request from panel side
	input  logic       mode,     // Step mode, stop in P0 after each instruction
	input  logic       przerw,   // Interrupt pending
	input  logic       bus_done, // Bus cycle completed
	input  word_t      ir,       // Instruction register
	output px_state_t  state,    // Current control state
	output bus_cycle_t cyc       // Bus need of current state
);

	px_state_t state_nx; // Next state

	// Successor of the last step of an instruction
	function automatic px_state_t instr_end(input logic irq, input logic step);
		px_state_t n;
		if (irq) begin
			n = I1; // Enter interrupt sequence
		end else if (step) begin
			n = P0; // Step mode, wait for next start
		end else begin
			n = K1; // Run on, fetch next
		end
		return n;
	endfunction

	always_comb begin
		state_nx = state; // Hold by default
		case (state)
			P0: begin
				if (start) begin
					state_nx = K1; // Begin fetch
				end
			end
			K1: begin
				if (bus_done) begin
					state_nx = K2; // Fetched word in ir
				end
			end
			K2: begin
				// Decode picks the operand access
				if (ir[15]) begin
					state_nx = WR;
				end else if (ir[14]) begin
					state_nx = WW;
				end else begin
					state_nx = instr_end(przerw, mode); // No operand
				end
			end
			WR, WW: begin
				if (bus_done) begin
					state_nx = instr_end(przerw, mode); // Operand done
				end
			end
			I1: begin
				state_nx = I2; // Accept takes one cycle
			end
			I2: begin
				if (bus_done) begin
					state_nx = I3; // Return address stored
				end
			end
			I3: begin
				if (bus_done) begin
					state_nx = instr_end(1'b0, mode); // Vector read, no nested irq
				end
			end
			default: begin
				state_nx = P0; // Unused codes recover to idle
			end
		endcase
	end

	// State register
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= P0;
		end else begin
			state <= state_nx;
		end
	end

	assign cyc = cycle_of(state); // Bus kind decoded from state

endmodule

`default_nettype wire

/* bus_pkg.sv */
// System bus package: data word and address source select codes
`default_nettype none

package bus_pkg;

	localparam int WORD_W = 16; // System bus data width

	typedef logic [WORD_W-1:0] word_t; // Bus data word

	// Address source put on the bus
	typedef logic [1:0] ad_sel_t;

	localparam ad_sel_t AD_NONE = 2'd0; // No address driven
	localparam ad_sel_t AD_IC   = 2'd1; // Instruction counter
	localparam ad_sel_t AD_AR   = 2'd2; // Argument address
	localparam ad_sel_t AD_VEC  = 2'd3; // Interrupt vector slot

endpackage

`default_nettype wire

/* px_pkg.sv */
// P-X control state package: machine states and the bus cycle kind of each state
`default_nettype none

package px_pkg;

	// Control states of the sequencer
	typedef enum logic [3:0] {
		P0, // Idle, waiting for start
		K1, // Instruction fetch
		K2, // Decode
		WR, // Operand read
		WW, // Operand write
		I1, // Interrupt accept
		I2, // Store return address
		I3  // Read interrupt vector
	} px_state_t;

	// Bus need of a state
	typedef enum logic [1:0] {
		BC_NONE,  // No bus access
		BC_READ,  // Memory read
		BC_WRITE  // Memory write
	} bus_cycle_t;

	// Bus cycle kind for a given state
	function automatic bus_cycle_t cycle_of(input px_state_t s);
		bus_cycle_t c;
		case (s)
			K1, WR, I3: c = BC_READ; // Fetch, operand and vector reads
			WW, I2:     c = BC_WRITE; // Operand and return address writes
			default:    c = BC_NONE; // P0, K2, I1 run without the bus
		endcase
		return c;
	endfunction

endpackage

`default_nettype wire
